// File: fix_pkg.sv
`default_nettype none

package fix_pkg;

	localparam int NUM_SESSIONS = 4;	// one slice per connected host
	localparam int SESSION_W    = 2;
	localparam int SEQ_W        = 10;	// holds 0..999
	localparam int CSUM_W       = 8;
	localparam int HB_INTERVAL  = 2000;	// idle cycles before a heartbeat
	localparam int HB_W         = 11;

	typedef logic [7:0]           byte_t;
	typedef logic [SESSION_W-1:0] session_id_t;
	typedef logic [SEQ_W-1:0]     seq_num_t;
	typedef logic [6:0]           tag_num_t;
	typedef logic [HB_W-1:0]      hb_count_t;

	localparam byte_t SOH     = 8'h01;	// field delimiter
	localparam byte_t EQ      = 8'h3d;	// '='
	localparam byte_t ASCII_0 = 8'h30;

	localparam byte_t MT_LOGON     = 8'h41;	// 'A'
	localparam byte_t MT_HEARTBEAT = 8'h30;	// '0'
	localparam byte_t MT_TEST_REQ  = 8'h31;	// '1'
	localparam byte_t MT_LOGOUT    = 8'h35;	// '5'

	localparam tag_num_t TAG_MSG_TYPE = 7'd35;
	localparam tag_num_t TAG_SEQ_NUM  = 7'd34;
	localparam tag_num_t TAG_CHECKSUM = 7'd10;

	typedef enum logic [1:0] {
		PS_TAG,		// collecting tag digits
		PS_VALUE,	// value of a tag we care about
		PS_SKIP		// value of any other tag
	} parse_state_t;

	typedef enum logic {
		SES_IDLE,
		SES_ACTIVE
	} session_state_t;

	typedef enum logic [2:0] {
		CS_IDLE,
		CS_TYPE,
		CS_SEQ,
		CS_CSUM,
		CS_DONE
	} compose_state_t;

endpackage

`default_nettype wire

// File: fix_parser.sv
`default_nettype none

module fix_parser (
	input  wire                         clk,
	input  wire                         arst_n_i,
	input  wire fix_pkg::byte_t         message_i,	// from offload engine
	input  wire                         byte_valid_i,
	input  wire fix_pkg::session_id_t   id_i,
	output logic                        evt_valid_o,	// to all slices
	output fix_pkg::byte_t              evt_type_o,
	output fix_pkg::session_id_t        evt_session_o
);

	import fix_pkg::*;

	parse_state_t      state;
	tag_num_t          tag_acc;	// tag of the current field
	logic [CSUM_W-1:0] sum;	// every byte of the message so far
	logic [CSUM_W-1:0] sum_field;	// sum up to and incl. the last SOH
	logic [9:0]        trailer_val;	// decimal value of 10=CCC
	logic              first_val;
	byte_t             msg_type;
	byte_t             digit;
	logic              trailer_end;
	logic              csum_ok;

	assign digit = message_i - ASCII_0;

	// closing SOH of the trailer field
	assign trailer_end = byte_valid_i && (state == PS_VALUE) && (message_i == SOH)
		&& (tag_acc == TAG_CHECKSUM);

	// trailer started right after the last SOH, so sum_field is the reference
	assign csum_ok = (trailer_val == 10'(sum_field));

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state       <= PS_TAG;
			tag_acc     <= '0;
			sum         <= '0;
			sum_field   <= '0;
			trailer_val <= '0;
			first_val   <= 1'b0;
			msg_type    <= '0;
			evt_valid_o <= 1'b0;
		end else begin
			evt_valid_o <= trailer_end && csum_ok;	// bad checksum drops silently
			if (byte_valid_i) begin
				sum <= sum + message_i;
				case (state)
					PS_TAG: begin
						if (message_i == EQ) begin
							if (tag_acc == TAG_MSG_TYPE || tag_acc == TAG_CHECKSUM) begin
								state <= PS_VALUE;
							end else begin
								state <= PS_SKIP;
							end
							first_val   <= 1'b1;
							trailer_val <= '0;
						end else if (message_i == SOH) begin
							tag_acc   <= '0;	// empty field
							sum_field <= sum + message_i;
						end else begin
							tag_acc <= tag_acc * 7'd10 + digit[6:0];
						end
					end
					PS_VALUE: begin
						if (message_i == SOH) begin
							state   <= PS_TAG;
							tag_acc <= '0;
							if (tag_acc == TAG_CHECKSUM) begin
								// message done, start clean for the next one
								sum       <= '0;
								sum_field <= '0;
								msg_type  <= '0;
							end else begin
								sum_field <= sum + message_i;
							end
						end else begin
							first_val <= 1'b0;
							if (first_val && tag_acc == TAG_MSG_TYPE) begin
								msg_type <= message_i;	// only the first char counts
							end
							trailer_val <= trailer_val * 10'd10 + 10'(digit);
						end
					end
					PS_SKIP: begin
						if (message_i == SOH) begin
							state     <= PS_TAG;
							tag_acc   <= '0;
							sum_field <= sum + message_i;
						end
					end
					default: state <= PS_TAG;
				endcase
			end
		end
	end

	// event payload, only meaningful with evt_valid_o
	always_ff @(posedge clk) begin
		if (trailer_end) begin
			evt_type_o    <= msg_type;
			evt_session_o <= id_i;	// all bytes of a message share id_i
		end
	end

endmodule

`default_nettype wire

// File: fix_session.sv
`default_nettype none

module fix_session #(
	parameter int SESSION_ID = 0	// slice index
) (
	input  wire                         clk,
	input  wire                         arst_n_i,
	input  wire                         evt_valid_i,	// from parser
	input  wire fix_pkg::byte_t         evt_type_i,
	input  wire fix_pkg::session_id_t   evt_session_i,
	input  wire                         grant_i,	// from composer
	output logic                        req_o,
	output fix_pkg::byte_t              req_type_o,
	output fix_pkg::seq_num_t           req_seq_o
);

	import fix_pkg::*;

	session_state_t state;
	seq_num_t       seq;	// outgoing sequence number
	hb_count_t      hb_cnt;	// idle cycles since last reply
	logic           hit;
	logic           hb_due;

	assign hit       = evt_valid_i && (evt_session_i == session_id_t'(SESSION_ID));
	assign hb_due    = (hb_cnt == hb_count_t'(HB_INTERVAL - 1));
	assign req_seq_o = seq;	// only moves after grant, so stable under req_o

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state      <= SES_IDLE;
			seq        <= seq_num_t'(1);
			hb_cnt     <= '0;
			req_o      <= 1'b0;
			req_type_o <= '0;
		end else if (req_o) begin
			// pending reply, new events are dropped
			if (grant_i) begin
				req_o  <= 1'b0;
				hb_cnt <= '0;
				if (seq == seq_num_t'(999)) begin
					seq <= '0;	// three digit wrap
				end else begin
					seq <= seq + 1'b1;
				end
			end
		end else if (hit && state == SES_IDLE && evt_type_i == MT_LOGON) begin
			state      <= SES_ACTIVE;
			seq        <= seq_num_t'(1);
			hb_cnt     <= '0;
			req_o      <= 1'b1;
			req_type_o <= MT_LOGON;
		end else if (hit && state == SES_ACTIVE && evt_type_i == MT_TEST_REQ) begin
			req_o      <= 1'b1;
			req_type_o <= MT_HEARTBEAT;
		end else if (hit && state == SES_ACTIVE && evt_type_i == MT_LOGOUT) begin
			state      <= SES_IDLE;	// seq restarts at next logon
			req_o      <= 1'b1;
			req_type_o <= MT_LOGOUT;
		end else if (state == SES_ACTIVE) begin
			if (hb_due) begin
				req_o      <= 1'b1;	// unsolicited heartbeat
				req_type_o <= MT_HEARTBEAT;
			end else begin
				hb_cnt <= hb_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: fix_composer.sv
`default_nettype none

module fix_composer (
	input  wire                                 clk,
	input  wire                                 arst_n_i,
	input  wire [fix_pkg::NUM_SESSIONS-1:0]     req_i,
	input  wire fix_pkg::byte_t                 req_type_i [fix_pkg::NUM_SESSIONS],
	input  wire fix_pkg::seq_num_t              req_seq_i [fix_pkg::NUM_SESSIONS],
	input  wire                                 fifo_full_i,
	output logic [fix_pkg::NUM_SESSIONS-1:0]    grant_o,
	output fix_pkg::byte_t                      message_o,	// goes to fifo
	output logic                                fifo_write_o,
	output fix_pkg::session_id_t                host_o,
	output logic                                end_o	// last byte of a reply
);

	import fix_pkg::*;

	compose_state_t    state;
	logic [2:0]        idx;	// byte position within a field
	session_id_t       last_grant;
	session_id_t       pick;
	logic              found;
	byte_t             type_q;
	seq_num_t          seq_q;
	session_id_t       host_q;
	logic [CSUM_W-1:0] sum;	// bytes before the trailer
	logic              field_last;

	function automatic byte_t dec_char(input logic [9:0] value, input int unsigned div);
		return byte_t'(ASCII_0 + (value / div) % 10);
	endfunction

	// round robin, search starts after the last granted slice
	always_comb begin
		session_id_t cand;
		pick  = last_grant;
		found = 1'b0;
		for (int k = 1; k <= NUM_SESSIONS; k++) begin
			cand = session_id_t'(last_grant + k);
			if (!found && req_i[cand]) begin
				pick  = cand;
				found = 1'b1;
			end
		end
	end

	always_comb begin
		grant_o = '0;
		if (state == CS_IDLE && found) begin
			grant_o[pick] = 1'b1;
		end
	end

	// 35=T is 5 bytes, 34=NNN 7 bytes, 10=CCC 6 bytes plus SOH in CS_DONE
	assign field_last = (state == CS_TYPE && idx == 3'd4)
		|| (state == CS_SEQ && idx == 3'd6)
		|| (state == CS_CSUM && idx == 3'd5);

	always_comb begin
		message_o = SOH;
		case (state)
			CS_TYPE: begin
				case (idx)
					3'd0: message_o = dec_char(10'(TAG_MSG_TYPE), 10);
					3'd1: message_o = dec_char(10'(TAG_MSG_TYPE), 1);
					3'd2: message_o = EQ;
					3'd3: message_o = type_q;
					default: message_o = SOH;
				endcase
			end
			CS_SEQ: begin
				case (idx)
					3'd0: message_o = dec_char(10'(TAG_SEQ_NUM), 10);
					3'd1: message_o = dec_char(10'(TAG_SEQ_NUM), 1);
					3'd2: message_o = EQ;
					3'd3: message_o = dec_char(seq_q, 100);
					3'd4: message_o = dec_char(seq_q, 10);
					3'd5: message_o = dec_char(seq_q, 1);
					default: message_o = SOH;
				endcase
			end
			CS_CSUM: begin
				case (idx)
					3'd0: message_o = dec_char(10'(TAG_CHECKSUM), 10);
					3'd1: message_o = dec_char(10'(TAG_CHECKSUM), 1);
					3'd2: message_o = EQ;
					3'd3: message_o = dec_char(10'(sum), 100);
					3'd4: message_o = dec_char(10'(sum), 10);
					default: message_o = dec_char(10'(sum), 1);
				endcase
			end
			default: message_o = SOH;	// closing SOH in CS_DONE
		endcase
	end

	assign fifo_write_o = (state != CS_IDLE) && !fifo_full_i;	// full stalls with byte held
	assign end_o        = (state == CS_DONE) && fifo_write_o;
	assign host_o       = host_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state      <= CS_IDLE;
			idx        <= '0;
			last_grant <= session_id_t'(NUM_SESSIONS - 1);	// slice 0 wins first
			sum        <= '0;
		end else if (state == CS_IDLE) begin
			if (found) begin
				state      <= CS_TYPE;
				idx        <= '0;
				sum        <= '0;
				last_grant <= pick;
			end
		end else if (fifo_write_o) begin
			if (state == CS_TYPE || state == CS_SEQ) begin
				sum <= sum + message_o;
			end
			idx <= field_last ? 3'd0 : idx + 3'd1;
			case (state)
				CS_TYPE: if (field_last) state <= CS_SEQ;
				CS_SEQ:  if (field_last) state <= CS_CSUM;
				CS_CSUM: if (field_last) state <= CS_DONE;
				default: state <= CS_IDLE;
			endcase
		end
	end

	// reply payload, latched at grant
	always_ff @(posedge clk) begin
		if (state == CS_IDLE && found) begin
			type_q <= req_type_i[pick];
			seq_q  <= req_seq_i[pick];
			host_q <= pick;
		end
	end

endmodule

`default_nettype wire

// File: fix_engine.sv
`default_nettype none

module fix_engine (
	input  wire                         clk,
	input  wire                         arst_n_i,
	input  wire fix_pkg::byte_t         message_i,	// from offload engine
	input  wire                         byte_valid_i,
	input  wire fix_pkg::session_id_t   id_i,
	input  wire                         fifo_full_i,
	output wire fix_pkg::byte_t         message_o,	// to outgoing fifo
	output wire                         fifo_write_o,
	output wire fix_pkg::session_id_t   host_o,
	output wire                         end_o
);

	import fix_pkg::*;

	wire                    evt_valid;
	wire byte_t             evt_type;
	wire session_id_t       evt_session;
	wire [NUM_SESSIONS-1:0] req;
	wire [NUM_SESSIONS-1:0] grant;
	wire byte_t             req_type [NUM_SESSIONS];
	wire seq_num_t          req_seq [NUM_SESSIONS];

	fix_parser u_parser (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.message_i     (message_i),
		.byte_valid_i  (byte_valid_i),
		.id_i          (id_i),
		.evt_valid_o   (evt_valid),
		.evt_type_o    (evt_type),
		.evt_session_o (evt_session)
	);

	// event is broadcast, each slice matches its own id
	for (genvar i = 0; i < NUM_SESSIONS; i++) begin : g_session
		fix_session #(
			.SESSION_ID (i)
		) u_session (
			.clk           (clk),
			.arst_n_i      (arst_n_i),
			.evt_valid_i   (evt_valid),
			.evt_type_i    (evt_type),
			.evt_session_i (evt_session),
			.grant_i       (grant[i]),
			.req_o         (req[i]),
			.req_type_o    (req_type[i]),
			.req_seq_o     (req_seq[i])
		);
	end

	fix_composer u_composer (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.req_i        (req),
		.req_type_i   (req_type),
		.req_seq_i    (req_seq),
		.fifo_full_i  (fifo_full_i),
		.grant_o      (grant),
		.message_o    (message_o),
		.fifo_write_o (fifo_write_o),
		.host_o       (host_o),
		.end_o        (end_o)
	);

endmodule

`default_nettype wire

// File: fix_engine_sva.sv
`default_nettype none

module fix_engine_sva (
	input wire                              clk,
	input wire                              arst_n_i,
	input wire                              fifo_full_i,
	input wire                              fifo_write_i,
	input wire                              end_i,
	input wire fix_pkg::session_id_t        host_i,
	input wire                              evt_valid_i,
	input wire [fix_pkg::NUM_SESSIONS-1:0]  req_i
);

	int unsigned fail_cnt = 0;	// failed assertions so far

	a_end_is_write: assert property (@(posedge clk) disable iff (!arst_n_i)
		end_i |-> fifo_write_i)
		else begin
			$error("end_o without fifo_write_o");
			fail_cnt++;
		end

	// a full fifo stalls the composer
	a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n_i)
		fifo_full_i |-> !fifo_write_i)
		else begin
			$error("fifo_write_o while fifo_full_i");
			fail_cnt++;
		end

	a_host_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
		fifo_write_i && !end_i |=> $stable(host_i))
		else begin
			$error("host_o changed within a reply");
			fail_cnt++;
		end

	a_reset_quiet: assert property (@(posedge clk)
		!arst_n_i |-> !fifo_write_i && !end_i && !evt_valid_i && req_i == '0)
		else begin
			$error("outputs active during reset");
			fail_cnt++;
		end

endmodule

bind fix_engine fix_engine_sva u_fix_engine_sva (
	.clk          (clk),
	.arst_n_i     (arst_n_i),
	.fifo_full_i  (fifo_full_i),
	.fifo_write_i (fifo_write_o),
	.end_i        (end_o),
	.host_i       (host_o),
	.evt_valid_i  (evt_valid),
	.req_i        (req)
);

`default_nettype wire

// File: tb_fix_engine.sv
`default_nettype none

module tb_fix_engine;

	import fix_pkg::*;

	localparam int REPLY_LEN     = 19;	// 35=T, 34=NNN, 10=CCC, each with SOH
	localparam int REPLY_TIMEOUT = 400;
	localparam int QUIET_CYCLES  = 80;
	localparam int HB_GUARD      = 300;	// drain a heartbeat due this soon
	localparam int RANDOM_MSGS   = 80;

	typedef byte_t frame_t [REPLY_LEN];

	logic        clk;
	logic        arst_n_i;
	byte_t       message_i;
	logic        byte_valid_i;
	session_id_t id_i;
	logic        fifo_full_i = 1'b0;
	byte_t       message_o;
	logic        fifo_write_o;
	session_id_t host_o;
	logic        end_o;

	// reference model, one entry per session
	bit    active [NUM_SESSIONS];
	int    next_seq [NUM_SESSIONS];
	bit    exp_pend [NUM_SESSIONS];
	byte_t exp_type [NUM_SESSIONS];
	int    exp_seq [NUM_SESSIONS];
	int    last_first [NUM_SESSIONS];	// cycle of the last reply's first byte
	int    hb_seen [NUM_SESSIONS];
	byte_t rx [REPLY_LEN];
	int    nbytes;
	int    cur_first;
	int    cycle;
	int    errors;
	int    test_errors;
	int    passed;
	int    failed;
	session_id_t cur_host;

	fix_engine u_fix_engine (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.message_i    (message_i),
		.byte_valid_i (byte_valid_i),
		.id_i         (id_i),
		.fifo_full_i  (fifo_full_i),
		.message_o    (message_o),
		.fifo_write_o (fifo_write_o),
		.host_o       (host_o),
		.end_o        (end_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (arst_n_i) fifo_full_i <= ($urandom % 4) == 0;	// random back-pressure
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input bit ok, input string what);
		assert (ok) else begin
			$display("ERROR: %s", what);
			errors++;
		end
	endtask

	function automatic byte_t ascii_digit(input int value);
		return byte_t'(48 + value % 10);
	endfunction

	function automatic int next_of(input int seq);
		return (seq == 999) ? 0 : seq + 1;
	endfunction

	function automatic byte_t pick_type();
		case (int'($urandom % 4))
			0: return MT_LOGON;
			1: return MT_HEARTBEAT;
			2: return MT_TEST_REQ;
			default: return MT_LOGOUT;
		endcase
	endfunction

	// trailer digits are the sum of bytes 0..11 mod 256, plus csum_err
	task automatic build_frame(input byte_t mtype, input int seq, input int csum_err,
			output frame_t f);
		int sum;
		f = '{8'h33, 8'h35, EQ, mtype, SOH, 8'h33, 8'h34, EQ, ascii_digit(seq / 100),
			ascii_digit(seq / 10), ascii_digit(seq), SOH, 8'h31, 8'h30, EQ, SOH, SOH, SOH, SOH};
		sum = csum_err;
		for (int i = 0; i < 12; i++) sum += int'(f[i]);
		sum = sum % 256;
		f[15] = ascii_digit(sum / 100);
		f[16] = ascii_digit(sum / 10);
		f[17] = ascii_digit(sum);
	endtask

	task automatic finish_reply(input int h, input int t0);
		frame_t ref_f;
		byte_t  rtype;
		int     rseq;
		if (exp_pend[h]) begin
			rtype       = exp_type[h];
			rseq        = exp_seq[h];
			exp_pend[h] = 1'b0;
		end else begin
			// without a request only a heartbeat of an active session may come
			check_true(active[h] && t0 - last_first[h] >= HB_INTERVAL - 20
				&& t0 - last_first[h] <= HB_INTERVAL + 200,
				$sformatf("unexpected reply for host %0d at cycle %0d", h, t0));
			rtype       = MT_HEARTBEAT;
			rseq        = next_seq[h];
			next_seq[h] = next_of(rseq);
			hb_seen[h]++;
		end
		last_first[h] = t0;
		build_frame(rtype, rseq, 0, ref_f);
		for (int i = 0; i < REPLY_LEN; i++)
			check_value($sformatf("message_o[%0d]", i), 32'(rx[i]), 32'(ref_f[i]));
	endtask

	// output monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (arst_n_i && fifo_write_o) begin
			if (nbytes == 0) begin
				cur_host  = host_o;
				cur_first = cycle;
			end
			check_value("host_o", 32'(host_o), 32'(cur_host));
			check_value("end_o", 32'(end_o), 32'(nbytes == REPLY_LEN - 1));
			rx[nbytes] = message_o;
			nbytes++;
			if (end_o || nbytes == REPLY_LEN) begin
				finish_reply(int'(cur_host), cur_first);
				nbytes = 0;
			end
		end
	end

	task automatic send_message(input int sid, input byte_t mtype, input bit corrupt);
		frame_t f;
		int     gap;
		build_frame(mtype, int'($urandom % 1000), corrupt ? int'(1 + $urandom % 255) : 0, f);
		for (int i = 0; i < REPLY_LEN; i++) begin
			gap = int'($urandom % 3);
			for (int g = 0; g < gap; g++) begin
				@(posedge clk);
				byte_valid_i <= 1'b0;
			end
			@(posedge clk);
			message_i    <= f[i];
			byte_valid_i <= 1'b1;
			id_i         <= session_id_t'(sid);
		end
		@(posedge clk);
		byte_valid_i <= 1'b0;
	endtask

	task automatic do_message(input int sid, input byte_t mtype, input bit corrupt);
		int    seen;
		byte_t rtype;
		// an event that meets a pending heartbeat request is dropped
		if (active[sid] && cycle - last_first[sid] > HB_INTERVAL - HB_GUARD) begin
			seen = hb_seen[sid];
			for (int i = 0; i < 2 * HB_GUARD && hb_seen[sid] == seen; i++) @(posedge clk);
			check_true(hb_seen[sid] != seen, $sformatf("no heartbeat from host %0d", sid));
		end
		send_message(sid, mtype, corrupt);
		rtype = 8'h00;
		if (!corrupt && !active[sid] && mtype == MT_LOGON) begin
			active[sid]   = 1'b1;
			next_seq[sid] = 1;
			rtype         = MT_LOGON;
		end else if (!corrupt && active[sid] && mtype == MT_TEST_REQ) begin
			rtype = MT_HEARTBEAT;
		end else if (!corrupt && active[sid] && mtype == MT_LOGOUT) begin
			active[sid] = 1'b0;
			rtype       = MT_LOGOUT;
		end
		if (rtype != 8'h00) begin
			exp_type[sid] = rtype;
			exp_seq[sid]  = next_seq[sid];
			next_seq[sid] = next_of(next_seq[sid]);
			exp_pend[sid] = 1'b1;
			for (int i = 0; i < REPLY_TIMEOUT && exp_pend[sid]; i++) @(posedge clk);
			check_true(!exp_pend[sid], $sformatf("no reply from host %0d in time", sid));
			exp_pend[sid] = 1'b0;
		end else begin
			for (int i = 0; i < QUIET_CYCLES; i++) @(posedge clk);
		end
	endtask

	task automatic end_test(input string name);
		if (errors == test_errors) begin
			$display("test %s: ok", name);
			passed++;
		end else begin
			$display("test %s: %0d errors", name, errors - test_errors);
			failed++;
		end
		test_errors = errors;
	endtask

	initial begin
		int seen_before [NUM_SESSIONS];
		bit done;
		int sva_errors;
		void'($urandom(32'h6c06));
		arst_n_i     = 1'b0;
		message_i    = '0;
		byte_valid_i = 1'b0;
		id_i         = '0;
		repeat (2) @(posedge clk);
		arst_n_i <= 1'b1;
		@(posedge clk);

		do_message(0, MT_LOGON, 1'b0);
		do_message(2, MT_LOGON, 1'b0);
		end_test("logon");
		do_message(0, MT_TEST_REQ, 1'b0);
		do_message(1, MT_TEST_REQ, 1'b0);	// idle, stays silent
		end_test("test request");
		do_message(2, MT_LOGOUT, 1'b0);
		do_message(2, MT_TEST_REQ, 1'b0);
		do_message(2, MT_LOGON, 1'b0);	// back to 001
		end_test("logout");
		do_message(0, MT_TEST_REQ, 1'b1);
		do_message(3, MT_LOGON, 1'b1);
		end_test("checksum");
		for (int n = 0; n < RANDOM_MSGS; n++)
			do_message(int'($urandom % NUM_SESSIONS), pick_type(), ($urandom % 8) == 0);
		end_test("random traffic with back-pressure");

		if (!active[0]) do_message(0, MT_LOGON, 1'b0);
		if (active[1]) do_message(1, MT_LOGOUT, 1'b0);
		for (int s = 0; s < NUM_SESSIONS; s++) seen_before[s] = hb_seen[s];
		for (int i = 0; i < HB_INTERVAL + HB_GUARD; i++) begin
			done = 1'b1;
			for (int s = 0; s < NUM_SESSIONS; s++)
				if (active[s] && hb_seen[s] == seen_before[s]) done = 1'b0;
			if (done) break;
			@(posedge clk);
		end
		for (int s = 0; s < NUM_SESSIONS; s++) begin
			if (active[s]) check_true(hb_seen[s] > seen_before[s],
				$sformatf("active host %0d sent no heartbeat", s));
			else check_value("idle heartbeat count", 32'(hb_seen[s]), 32'(seen_before[s]));
		end
		end_test("heartbeat");

		sva_errors = int'(u_fix_engine.u_fix_engine_sva.fail_cnt);
		$display("%0d tests passed, %0d failed, %0d check errors, %0d assertion errors",
			passed, failed, errors, sva_errors);
		if (errors == 0 && failed == 0 && sva_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
fix_pkg.sv
fix_parser.sv
fix_session.sv
fix_composer.sv
fix_engine.sv
fix_engine_sva.sv
tb_fix_engine.sv

// File: Makefile
TOP := tb_fix_engine

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module fix_engine \
		fix_pkg.sv fix_parser.sv fix_session.sv fix_composer.sv fix_engine.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
